// ==== files.f ====
logic/warp_pkg.sv
logic/ib_ptr_if.sv
logic/scb_if.sv
logic/ib_pointer_counter.sv
logic/issue_fsm.sv
logic/ibuffer_store.sv
logic/scoreboard.sv
logic/warp_issue_top.sv
bench/warp_issue_checker.sv
bench/tb_warp_issue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_warp_issue -o sim_warp_issue

out="$(./obj_dir/sim_warp_issue)"
echo "$out"

if grep -q "^sim passed$" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== bench/tb_warp_issue.sv ====
`timescale 1ns/10ps

module tb_warp_issue
    import warp_pkg::*;
();

    localparam int NUM_THREADS = 8;
    localparam int NUM_INSTR   = 20;
    localparam int TIMEOUT_NS  = NUM_INSTR * 40 * 100;

    logic                   clk;
    logic                   rst;
    logic                   fetch_valid;
    logic                   fetch_req;
    logic                   dec_valid;
    logic                   dec_drop;
    instr_t                 dec_instr;
    logic [NUM_THREADS-1:0] dec_mask;
    logic                   issue_req;
    logic                   issue_grant;
    instr_t                 oc_instr;
    scb_id_t                oc_scb_id;
    logic                   oc_replay;
    logic                   exit_req;
    logic                   exit_grant;
    logic                   wb_clear_valid;
    scb_id_t                wb_clear_id;
    logic                   mem_pos_valid;
    logic [NUM_THREADS-1:0] mem_pos_mask;
    logic                   mem_zero_valid;

    integer  seed = 32'h9b4d_ceca;
    int      errors = 0;
    logic    grant_on = 1'b1;
    logic    wb_auto = 1'b1;
    logic    manual_clear_req = 1'b0;
    scb_id_t manual_clear_id = '0;

    ////////////////////
    // reference model state
    ////////////////////
    instr_t                 model_q [$];       // in-order queue of expected issues
    scb_id_t                clear_q [$];       // ids waiting for write-back
    logic [SCB_DEPTH-1:0]   scb_valid = '0;
    reg_id_t                scb_dst [SCB_DEPTH];
    logic                   mem_active = 1'b0;
    logic                   replay_expected = 1'b0;
    logic [NUM_THREADS-1:0] mem_mask = '0;
    scb_id_t                mem_id = '0;
    instr_t                 mem_instr;
    scb_id_t                last_id = '0;
    int                     issue_count = 0;
    int                     replay_count = 0;

    warp_issue_top #(.NUM_THREADS(NUM_THREADS)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
        else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else begin
            errors++;
            $display("ERROR: %s", msg);
        end
    endtask

    function automatic logic same_reg(reg_id_t a, reg_id_t b);
        return a.valid && b.valid && (a.num == b.num);
    endfunction

    // head may issue only when no outstanding destination touches its registers
    function automatic logic model_dependent(instr_t ins);
        logic dep;
        dep = 1'b0;
        for (int i = 0; i < SCB_DEPTH; i++) begin
            if (scb_valid[i] && (same_reg(scb_dst[i], ins.src1) || same_reg(scb_dst[i], ins.src2)
                                 || same_reg(scb_dst[i], ins.dst)))
                dep = 1'b1;
        end
        return dep;
    endfunction

    function automatic scb_id_t model_free_id();
        scb_id_t id;
        id = '0;
        for (int i = SCB_DEPTH - 1; i >= 0; i--) begin
            if (!scb_valid[i])
                id = scb_id_t'(i);
        end
        return id;
    endfunction

    function automatic instr_t random_alu();
        instr_t      ins;
        logic [31:0] r;
        ins = '0;
        ins.word = $random(seed);
        r = $random(seed);
        ins.src1 = {r[0], r[5:1]};
        ins.src2 = {r[6], r[11:7]};
        ins.dst = {1'b1, r[16:12]};
        ins.alu_op = r[20:17];
        return ins;
    endfunction

    ////////////////////
    // compare process, sampled mid-cycle
    ////////////////////
    initial begin : compare
        instr_t  exp;
        scb_id_t alloc_id;
        logic    normal_go;
        logic    replay_go;
        forever begin
            @(negedge clk);
            if (rst) begin
                normal_go = issue_req && issue_grant && !oc_replay && (model_q.size() > 0);
                replay_go = issue_req && issue_grant && oc_replay;
                alloc_id = model_free_id();
                if (exit_req)
                    check_true(scb_valid == '0, "exit_req raised with destinations outstanding");
                if (issue_req && issue_grant && !oc_replay && model_q.size() == 0)
                    check_true(1'b0, "issue granted with nothing left to issue");
                if (normal_go) begin
                    exp = model_q.pop_front();
                    check_val("issue order", 64'(exp), 64'(oc_instr));
                    check_val("issue scb id", 64'(alloc_id), 64'(oc_scb_id));
                    check_true(!model_dependent(exp), "issue despite a register dependency");
                    check_true(scb_valid != '1, "issue with a full scoreboard");
                end
                if (replay_go) begin
                    check_true(replay_expected, "replay issued without memory feedback");
                    check_val("replay instr", 64'(mem_instr), 64'(oc_instr));
                    check_val("replay scb id", 64'(mem_id), 64'(oc_scb_id));
                    replay_expected = 1'b0;
                    replay_count++;
                end
                if (wb_clear_valid)
                    scb_valid[wb_clear_id] = 1'b0;
                if (mem_zero_valid && mem_active)
                    replay_expected = 1'b1;
                if (mem_pos_valid && mem_active) begin
                    mem_mask = mem_mask & ~mem_pos_mask;
                    if (mem_mask == '0) begin
                        scb_valid[mem_id] = 1'b0;   // completion frees the entry
                        mem_active = 1'b0;
                    end else begin
                        replay_expected = 1'b1;
                    end
                end
                if (normal_go) begin
                    scb_valid[alloc_id] = 1'b1;
                    scb_dst[alloc_id] = exp.dst;
                    last_id = alloc_id;
                    issue_count++;
                    if (exp.mem_read || exp.mem_write) begin
                        mem_active = 1'b1;
                        mem_id = alloc_id;
                        mem_instr = exp;
                    end else if (wb_auto) begin
                        clear_q.push_back(alloc_id);
                    end
                end
            end
        end
    end

    // issue arbiter with random grant delay
    initial begin : arbiter
        logic [31:0] r;
        forever begin
            @(posedge clk);
            #10;
            r = $random(seed);
            issue_grant = grant_on && issue_req && r[0];
        end
    end

    initial begin : writeback
        forever begin
            @(posedge clk);
            #10;
            if (wb_auto && clear_q.size() > 0) begin
                wb_clear_valid = 1'b1;
                wb_clear_id = clear_q.pop_front();
            end else if (manual_clear_req) begin
                wb_clear_valid = 1'b1;
                wb_clear_id = manual_clear_id;
                manual_clear_req = 1'b0;
            end else begin
                wb_clear_valid = 1'b0;
            end
        end
    end

    task automatic decode(input instr_t ins, input logic [NUM_THREADS-1:0] mask, input logic drop);
        @(negedge clk);
        while (!fetch_req)
            @(negedge clk);
        @(posedge clk);
        #10;
        dec_valid = 1'b1;
        dec_drop = drop;
        dec_instr = ins;
        dec_mask = mask;
        if (!drop && !ins.exit)
            model_q.push_back(ins);
        @(posedge clk);
        #10;
        dec_valid = 1'b0;
        dec_drop = 1'b0;
    endtask

    task automatic wait_issues(input int target);
        while (issue_count < target)
            @(negedge clk);
    endtask

    task automatic wait_replay();
        int target;
        target = replay_count + 1;
        while (replay_count < target)
            @(negedge clk);
    endtask

    task automatic wait_idle();
        while (model_q.size() > 0 || clear_q.size() > 0 || scb_valid != '0 || manual_clear_req)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic clear_manual(input scb_id_t id);
        manual_clear_id = id;
        manual_clear_req = 1'b1;
        while (manual_clear_req)
            @(negedge clk);
    endtask

    task automatic feedback(input logic zero, input logic pos, input logic [NUM_THREADS-1:0] mask);
        @(posedge clk);
        #10;
        mem_zero_valid = zero;
        mem_pos_valid = pos;
        mem_pos_mask = mask;
        @(posedge clk);
        #10;
        mem_zero_valid = 1'b0;
        mem_pos_valid = 1'b0;
    endtask

    initial begin : stimulus
        instr_t      ins;
        logic [31:0] r;
        rst = 1'b0;
        fetch_valid = 1'b0;
        dec_valid = 1'b0;
        dec_drop = 1'b0;
        dec_instr = '0;
        dec_mask = '0;
        issue_grant = 1'b0;
        exit_grant = 1'b0;
        wb_clear_valid = 1'b0;
        wb_clear_id = '0;
        mem_pos_valid = 1'b0;
        mem_pos_mask = '0;
        mem_zero_valid = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b1;

        // reset values
        @(negedge clk);
        check_val("reset fetch_req", 64'(1), 64'(fetch_req));
        check_val("reset issue_req", 64'(0), 64'(issue_req));
        check_val("reset exit_req", 64'(0), 64'(exit_req));
        check_val("reset oc_replay", 64'(0), 64'(oc_replay));

        // in-order issue with dropped decodes mixed in
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            decode(random_alu(), r[NUM_THREADS-1:0], 1'b0);
            if (i % 4 == 1)
                decode(random_alu(), r[NUM_THREADS-1:0], 1'b1);
        end
        wait_idle();

        ////////////////////
        // dependency on an outstanding destination
        ////////////////////
        wb_auto = 1'b0;
        ins = '0;
        ins.dst = {1'b1, 5'd5};
        decode(ins, '1, 1'b0);
        wait_issues(issue_count + 1);
        ins = '0;
        ins.word = 32'h0000_0123;
        ins.src1 = {1'b1, 5'd5};
        decode(ins, '1, 1'b0);
        repeat (6) begin
            @(negedge clk);
            check_val("dependent issue_req", 64'(0), 64'(issue_req));
        end
        clear_manual(last_id);
        wait_issues(issue_count + 1);
        clear_manual(last_id);
        wb_auto = 1'b1;
        wait_idle();

        // memory replay on miss, then partial and full completion
        ins = '0;
        ins.word = 32'h8000_0042;
        ins.dst = {1'b1, 5'd9};
        ins.mem_read = 1'b1;
        mem_mask = '1;
        decode(ins, '1, 1'b0);
        wait_issues(issue_count + 1);
        feedback(1'b1, 1'b0, '0);
        wait_replay();
        feedback(1'b0, 1'b1, 8'h0f);
        wait_replay();
        feedback(1'b0, 1'b1, 8'hf0);
        repeat (6) begin
            @(negedge clk);
            check_val("completed issue_req", 64'(0), 64'(issue_req));
            check_val("completed oc_replay", 64'(0), 64'(oc_replay));
        end
        // a reader of the load's destination issues once the entry is freed
        ins = '0;
        ins.word = 32'h0000_0456;
        ins.src1 = {1'b1, 5'd9};
        decode(ins, '1, 1'b0);
        wait_issues(issue_count + 1);
        wait_idle();

        // full buffer without grants
        grant_on = 1'b0;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            decode(random_alu(), r[NUM_THREADS-1:0], 1'b0);
        end
        @(negedge clk);
        check_val("full fetch_req", 64'(0), 64'(fetch_req));
        grant_on = 1'b1;
        wait_issues(issue_count + 1);
        @(negedge clk);
        check_val("refill fetch_req", 64'(1), 64'(fetch_req));
        wait_idle();

        ////////////////////
        // exit waits for the scoreboard
        ////////////////////
        wb_auto = 1'b0;
        ins = '0;
        ins.dst = {1'b1, 5'd3};
        decode(ins, '1, 1'b0);
        wait_issues(issue_count + 1);
        ins = '0;
        ins.exit = 1'b1;
        decode(ins, '1, 1'b0);
        repeat (4) begin
            @(negedge clk);
            check_val("early exit_req", 64'(0), 64'(exit_req));
        end
        clear_manual(last_id);
        while (!exit_req)
            @(negedge clk);
        @(posedge clk);
        #10;
        exit_grant = 1'b1;
        @(posedge clk);
        #10;
        exit_grant = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_val("done issue_req", 64'(0), 64'(issue_req));
            check_val("done exit_req", 64'(0), 64'(exit_req));
            check_val("done fetch_req", 64'(0), 64'(fetch_req));
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== bench/warp_issue_checker.sv ====
`timescale 1ns/10ps

module warp_issue_checker (
    input logic clk,
    input logic rst,
    input logic issue_req,
    input logic issue_grant,
    input logic exit_req,
    input logic fetch_req
);

    // exit and normal issue are exclusive
    a_exit_alone: assert property (@(posedge clk) disable iff (!rst)
        !(exit_req && issue_req))
        else $error("exit_req raised while issue_req is high");

    // an ungranted request stays up
    a_req_hold: assert property (@(posedge clk) disable iff (!rst)
        (issue_req && !issue_grant) |=> issue_req)
        else $error("issue_req dropped before issue_grant");

    a_fetch_reset: assert property (@(posedge clk)
        $rose(rst) |-> fetch_req)
        else $error("fetch_req low right after reset");

endmodule

bind warp_issue_top warp_issue_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .issue_req   (issue_req),
    .issue_grant (issue_grant),
    .exit_req    (exit_req),
    .fetch_req   (fetch_req)
);

// ==== logic/warp_issue_top.sv ====
`timescale 1ns/10ps

module warp_issue_top
    import warp_pkg::*;
#(
    parameter int NUM_THREADS = 8
) (
    input  logic                   clk,
    input  logic                   rst,

    // fetch and decode
    input  logic                   fetch_valid,
    output logic                   fetch_req,
    input  logic                   dec_valid,
    input  logic                   dec_drop,
    input  instr_t                 dec_instr,
    input  logic [NUM_THREADS-1:0] dec_mask,

    // issue arbiter and operand collector
    output logic                   issue_req,
    input  logic                   issue_grant,
    output instr_t                 oc_instr,
    output scb_id_t                oc_scb_id,
    output logic                   oc_replay,
    output logic                   exit_req,
    input  logic                   exit_grant,

    // write-back and memory feedback
    input  logic                   wb_clear_valid,
    input  scb_id_t                wb_clear_id,
    input  logic                   mem_pos_valid,
    input  logic [NUM_THREADS-1:0] mem_pos_mask,
    input  logic                   mem_zero_valid
);

    logic head_valid;
    logic head_exit;
    logic replay_pending;
    logic replay_grant;

    ib_ptr_if ptr_bus ();
    scb_if    scb_bus ();

    ib_pointer_counter u_counter (
        .clk         (clk),
        .rst         (rst),
        .ptr         (ptr_bus.counter),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req)
    );

    issue_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .ptr            (ptr_bus.fsm),
        .scb            (scb_bus.fsm),
        .head_valid     (head_valid),
        .head_exit      (head_exit),
        .replay_pending (replay_pending),
        .issue_grant    (issue_grant),
        .exit_grant     (exit_grant),
        .issue_req      (issue_req),
        .exit_req       (exit_req),
        .oc_replay      (oc_replay),
        .replay_grant   (replay_grant)
    );

    ibuffer_store #(
        .NUM_THREADS (NUM_THREADS)
    ) u_store (
        .clk            (clk),
        .rst            (rst),
        .ptr            (ptr_bus.store),
        .scb            (scb_bus.store),
        .dec_valid      (dec_valid),
        .dec_drop       (dec_drop),
        .dec_instr      (dec_instr),
        .dec_mask       (dec_mask),
        .mem_pos_valid  (mem_pos_valid),
        .mem_zero_valid (mem_zero_valid),
        .mem_pos_mask   (mem_pos_mask),
        .replay_grant   (replay_grant),
        .oc_replay      (oc_replay),
        .head_valid     (head_valid),
        .head_exit      (head_exit),
        .replay_pending (replay_pending),
        .oc_instr       (oc_instr),
        .oc_scb_id      (oc_scb_id)
    );

    scoreboard u_scb (
        .clk            (clk),
        .rst            (rst),
        .scb            (scb_bus.scb),
        .wb_clear_valid (wb_clear_valid),
        .wb_clear_id    (wb_clear_id)
    );

endmodule

// ==== logic/scoreboard.sv ====
`timescale 1ns/10ps

module scoreboard
    import warp_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    scb_if.scb      scb,
    input  logic    wb_clear_valid,
    input  scb_id_t wb_clear_id
);

    logic [SCB_DEPTH-1:0] valid_q;
    logic [SCB_DEPTH-1:0] incomplete_q;   // memory op still replaying
    logic [SCB_DEPTH-1:0] hit;
    reg_id_t              dst_q [SCB_DEPTH];
    logic                 release_ok;

    function automatic logic same_reg(reg_id_t a, reg_id_t b);
        return a.valid && b.valid && (a.num == b.num);
    endfunction

    ////////////////////
    // status
    ////////////////////
    always_comb begin
        scb.free_id = '0;
        for (int i = SCB_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i])
                scb.free_id = scb_id_t'(i);     // lowest free entry wins
        end
    end

    always_comb begin
        for (int i = 0; i < SCB_DEPTH; i++) begin
            hit[i] = valid_q[i] && (same_reg(dst_q[i], scb.src1)
                                 || same_reg(dst_q[i], scb.src2)
                                 || same_reg(dst_q[i], scb.dst));   // raw and waw
        end
    end

    assign scb.full      = &valid_q;
    assign scb.empty     = ~|valid_q;
    assign scb.dependent = |hit;

    // stores always release, a load only while its entry is still the incomplete one
    assign release_ok = scb.complete_store || incomplete_q[scb.complete_id];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q      <= '0;
            incomplete_q <= '0;
        end else begin
            if (wb_clear_valid) begin
                valid_q[wb_clear_id]      <= 1'b0;
                incomplete_q[wb_clear_id] <= 1'b0;
            end
            if (scb.complete && release_ok) begin
                valid_q[scb.complete_id]      <= 1'b0;
                incomplete_q[scb.complete_id] <= 1'b0;
            end
            if (scb.alloc) begin
                valid_q[scb.free_id]      <= 1'b1;
                incomplete_q[scb.free_id] <= scb.replayable;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scb.alloc)
            dst_q[scb.free_id] <= scb.dst;
    end

endmodule

// ==== logic/ibuffer_store.sv ====
`timescale 1ns/10ps

module ibuffer_store
    import warp_pkg::*;
#(
    parameter int NUM_THREADS = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    ib_ptr_if.store                ptr,
    scb_if.store                   scb,
    input  logic                   dec_valid,
    input  logic                   dec_drop,
    input  instr_t                 dec_instr,
    input  logic [NUM_THREADS-1:0] dec_mask,
    input  logic                   mem_pos_valid,
    input  logic                   mem_zero_valid,
    input  logic [NUM_THREADS-1:0] mem_pos_mask,
    input  logic                   replay_grant,
    input  logic                   oc_replay,
    output logic                   head_valid,
    output logic                   head_exit,
    output logic                   replay_pending,
    output instr_t                 oc_instr,
    output scb_id_t                oc_scb_id
);

    instr_t                 instr_q  [IB_DEPTH];
    logic [NUM_THREADS-1:0] mask_q   [IB_DEPTH];   // private active mask
    scb_id_t                scb_id_q [IB_DEPTH];
    logic [IB_DEPTH-1:0]    valid_q;
    logic [IB_DEPTH-1:0]    replay_q;
    logic [IB_DEPTH-1:0]    valid_nxt;
    logic [IB_DEPTH-1:0]    replay_nxt;
    logic [NUM_THREADS-1:0] mask_nxt;
    logic                   still_waiting;

    assign ptr.wr_en = dec_valid && !dec_drop;

    ////////////////////
    // memory feedback
    ////////////////////
    assign mask_nxt = mem_pos_valid ? (mask_q[ptr.replay_idx] & ~mem_pos_mask)
                                    : mask_q[ptr.replay_idx];
    assign scb.complete  = mem_pos_valid && valid_q[ptr.replay_idx] && (mask_nxt == '0);
    assign still_waiting = mem_zero_valid || (mem_pos_valid && (mask_nxt != '0));

    always_comb begin
        valid_nxt = valid_q;
        if (scb.complete)
            valid_nxt[ptr.replay_idx] = 1'b0;
        if (ptr.rd_en && !replay_q[ptr.rd_idx])
            valid_nxt[ptr.rd_idx] = 1'b0;           // non-memory leaves on its grant
    end

    always_comb begin
        replay_nxt = replay_q;
        if (still_waiting)
            replay_nxt[ptr.replay_idx] = 1'b1;
        if (replay_grant)
            replay_nxt[ptr.replay_idx] = 1'b0;
        if (ptr.rd_en)
            replay_nxt[ptr.rd_idx] = 1'b0;
        if (ptr.wr_en)
            replay_nxt[ptr.wr_idx] = dec_instr.mem_read || dec_instr.mem_write;
    end

    assign ptr.replay_retire = !valid_nxt[ptr.replay_idx];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q  <= '0;
            replay_q <= '0;
        end else begin
            valid_q  <= valid_nxt;
            replay_q <= replay_nxt;
            if (ptr.wr_en)
                valid_q[ptr.wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_pos_valid)
            mask_q[ptr.replay_idx] <= mask_nxt;
        if (ptr.rd_en)
            scb_id_q[ptr.rd_idx] <= scb.free_id;    // kept for replays and completion
        if (ptr.wr_en) begin
            instr_q[ptr.wr_idx] <= dec_instr;
            mask_q[ptr.wr_idx]  <= dec_mask;
        end
    end

    ////////////////////
    // head and replay views
    ////////////////////
    assign head_valid     = valid_q[ptr.rd_idx];
    assign head_exit      = instr_q[ptr.rd_idx].exit;
    assign replay_pending = !ptr.at_head && valid_q[ptr.replay_idx]
                            && (replay_q[ptr.replay_idx] || still_waiting);

    assign oc_instr  = oc_replay ? instr_q[ptr.replay_idx] : instr_q[ptr.rd_idx];
    assign oc_scb_id = oc_replay ? scb_id_q[ptr.replay_idx] : scb.free_id;

    assign scb.src1           = instr_q[ptr.rd_idx].src1;
    assign scb.src2           = instr_q[ptr.rd_idx].src2;
    assign scb.dst            = instr_q[ptr.rd_idx].dst;
    assign scb.replayable     = replay_q[ptr.rd_idx];
    assign scb.complete_id    = scb_id_q[ptr.replay_idx];
    assign scb.complete_store = instr_q[ptr.replay_idx].mem_write;

endmodule

// ==== logic/issue_fsm.sv ====
`timescale 1ns/10ps

module issue_fsm (
    input  logic     clk,
    input  logic     rst,
    ib_ptr_if.fsm    ptr,
    scb_if.fsm       scb,
    input  logic     head_valid,
    input  logic     head_exit,
    input  logic     replay_pending,
    input  logic     issue_grant,
    input  logic     exit_grant,
    output logic     issue_req,
    output logic     exit_req,
    output logic     oc_replay,
    output logic     replay_grant
);

    typedef enum logic [1:0] {
        ISSUE,
        REPLAY,
        EXIT_WAIT,
        DONE
    } state_t;

    state_t state_q;
    state_t state_nxt;
    logic   normal_ok;

    // head may go out when nothing in flight blocks it
    assign normal_ok = head_valid && !head_exit && !scb.full && !scb.dependent;

    always_comb begin
        state_nxt = state_q;
        issue_req = 1'b0;
        exit_req  = 1'b0;
        oc_replay = 1'b0;
        case (state_q)
            ISSUE: begin
                issue_req = normal_ok;
                // a raised normal request is kept until it is granted
                if (replay_pending && !(normal_ok && !issue_grant))
                    state_nxt = REPLAY;
                else if (head_valid && head_exit)
                    state_nxt = EXIT_WAIT;
            end
            REPLAY: begin
                issue_req = replay_pending;
                oc_replay = 1'b1;                       // operands come from the replay entry
                if (issue_grant || !replay_pending)
                    state_nxt = ISSUE;
            end
            EXIT_WAIT: begin
                exit_req = scb.empty;                   // wait for every destination to drain
                if (exit_req && exit_grant)
                    state_nxt = DONE;
                else if (replay_pending)
                    state_nxt = REPLAY;                 // misses still have to finish
            end
            default: begin
                state_nxt = DONE;                       // warp finished, only reset leaves
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            state_q <= ISSUE;
        else
            state_q <= state_nxt;
    end

    assign ptr.rd_en     = (state_q == ISSUE) && issue_req && issue_grant;
    assign scb.alloc     = ptr.rd_en;
    assign replay_grant  = oc_replay && issue_req && issue_grant;
    assign ptr.warp_done = (state_q == DONE);

endmodule

// ==== logic/ib_pointer_counter.sv ====
`timescale 1ns/10ps

module ib_pointer_counter
    import warp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    ib_ptr_if.counter  ptr,
    input  logic       fetch_valid,
    output logic       fetch_req
);

    localparam int PTR_W = $clog2(IB_DEPTH) + 1;   // extra bit tells full from empty
    localparam int DEM_W = PTR_W + 1;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rp_ptr;
    logic [PTR_W-1:0] rd_nxt;
    logic [PTR_W-1:0] depth;
    logic [DEM_W-1:0] demand;

    assign rd_nxt = rd_ptr + PTR_W'(ptr.rd_en);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rp_ptr <= '0;
        end else begin
            if (ptr.wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            rd_ptr <= rd_nxt;
            // replay pointer walks up behind the read pointer, one retired entry per cycle
            if (ptr.replay_retire && (rp_ptr != rd_nxt))
                rp_ptr <= rp_ptr + 1'b1;
        end
    end

    assign ptr.wr_idx     = wr_ptr[PTR_W-2:0];
    assign ptr.rd_idx     = rd_ptr[PTR_W-2:0];
    assign ptr.replay_idx = rp_ptr[PTR_W-2:0];
    assign ptr.at_head    = (rd_ptr == rp_ptr);

    // entries still held, counted from the oldest unretired one
    assign depth  = wr_ptr - rp_ptr;
    assign demand = {1'b0, depth} + DEM_W'(fetch_valid) + DEM_W'(ptr.wr_en);

    assign fetch_req = !ptr.warp_done && (demand < DEM_W'(IB_DEPTH));

endmodule

// ==== logic/scb_if.sv ====
`timescale 1ns/10ps

interface scb_if
    import warp_pkg::*;
();

    // operands of the instruction at the read pointer
    reg_id_t src1;
    reg_id_t src2;
    reg_id_t dst;
    logic    replayable;    // head is a memory instruction

    logic    alloc;         // normal issue, take a new entry

    // replay completion
    logic    complete;
    scb_id_t complete_id;
    logic    complete_store;

    // status back to the buffer side
    logic    full;
    logic    empty;
    logic    dependent;
    scb_id_t free_id;

    modport store (
        output src1, src2, dst, replayable, complete, complete_id, complete_store,
        input  free_id
    );

    modport fsm (
        output alloc,
        input  full, empty, dependent
    );

    modport scb (
        input  src1, src2, dst, replayable, alloc, complete, complete_id, complete_store,
        output full, empty, dependent, free_id
    );

endinterface

// ==== logic/ib_ptr_if.sv ====
`timescale 1ns/10ps

interface ib_ptr_if
    import warp_pkg::*;
();

    logic [$clog2(IB_DEPTH)-1:0] wr_idx;
    logic [$clog2(IB_DEPTH)-1:0] rd_idx;
    logic [$clog2(IB_DEPTH)-1:0] replay_idx;
    logic                        at_head;       // replay pointer caught up with read pointer
    logic                        wr_en;
    logic                        rd_en;         // normal issue grant
    logic                        replay_retire; // entry under the replay pointer is gone
    logic                        warp_done;     // exit granted, stop fetching

    modport counter (
        output wr_idx, rd_idx, replay_idx, at_head,
        input  wr_en, rd_en, replay_retire, warp_done
    );

    modport store (
        input  wr_idx, rd_idx, replay_idx, at_head, rd_en,
        output wr_en, replay_retire
    );

    modport fsm (
        output rd_en, warp_done
    );

endinterface

// ==== logic/warp_pkg.sv ====
package warp_pkg;

    ////////////////////
    // buffer sizes
    ////////////////////
    localparam int IB_DEPTH  = 4;    // instruction buffer entries per warp
    localparam int SCB_DEPTH = 4;    // outstanding destinations per warp

    typedef logic [$clog2(SCB_DEPTH)-1:0] scb_id_t;

    // register operand, msb marks the operand as used
    typedef struct packed {
        logic       valid;
        logic [4:0] num;
    } reg_id_t;

    ////////////////////
    // decoded instruction
    ////////////////////
    typedef struct packed {
        logic [31:0] word;      // raw encoding, passed on to the operand collector
        reg_id_t     src1;
        reg_id_t     src2;
        reg_id_t     dst;
        logic [3:0]  alu_op;
        logic        mem_read;
        logic        mem_write;
        logic        exit;
    } instr_t;

endpackage
